// ==== cpu_control.sv ====
// Main control unit of the multi-cycle core.
// Decodes the opcode of the current instruction and steps the FSM through
// fetch, decode, execute, memory access and write-back. Every instruction
// ends in S_DONE, and o_io_stall is low for that one cycle.
module cpu_control (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [isa_cpu_pkg::INSTR_W-1:0] i_instr,
    input  logic                            i_imem_valid,
    input  logic                            i_mem_done,
    output isa_cpu_pkg::cpu_state_e         o_state,
    output logic                            o_io_stall
);
    import isa_cpu_pkg::*;

    cpu_state_e state_q;
    cpu_state_e state_d;
    opcode_e    opcode;

    assign opcode = opcode_e'(i_instr[OPC_MSB:OPC_LSB]);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= S_FETCH;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // ====================
    // Next state
    // ====================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_FETCH:
            begin
                state_d = S_FETCH_WAIT;
            end
            S_FETCH_WAIT:
            begin
                state_d = i_imem_valid ? S_DECODE : S_FETCH_WAIT;
            end
            S_DECODE:
            begin
                case (opcode)
                    OP_RTYPE0, OP_RTYPE1, OP_LW, OP_SW, OP_BEQ: state_d = S_EXEC;
                    // J finishes in decode, reserved opcodes do nothing
                    OP_J, OP_RSV6, OP_RSV7:                     state_d = S_DONE;
                    default:                                    state_d = S_DONE;
                endcase
            end
            S_EXEC:
            begin
                case (opcode)
                    OP_RTYPE0, OP_RTYPE1: state_d = S_R_WB;
                    OP_LW, OP_SW:         state_d = S_MEM_REQ;
                    default:              state_d = S_DONE;
                endcase
            end
            S_R_WB:
            begin
                state_d = S_DONE;
            end
            S_MEM_REQ:
            begin
                state_d = S_MEM_WAIT;
            end
            S_MEM_WAIT:
            begin
                if (i_mem_done)
                begin
                    // Stores have nothing to write back
                    state_d = (opcode == OP_LW) ? S_MEM_WB : S_DONE;
                end
            end
            S_MEM_WB:
            begin
                state_d = S_DONE;
            end
            default:
            begin
                state_d = S_FETCH;
            end
        endcase
    end

    // Stall drops for the single S_DONE cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_io_stall <= 1'b1;
        end
        else
        begin
            o_io_stall <= (state_d != S_DONE);
        end
    end

    assign o_state = state_q;

endmodule

// ==== cpu_execute.sv ====
// Execute unit.
// Latches rs and rt in decode and computes the ALU result in execute. The
// result is an R-type value, a load/store word index or a branch target.
// It also flags a taken BEQ and drives the register write-back port.
// The data width must be at least the 16-bit address width.
module cpu_execute #(
    parameter int DATA_W_P = isa_cpu_pkg::DATA_W
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  isa_cpu_pkg::cpu_state_e            i_state,
    input  logic [isa_cpu_pkg::INSTR_W-1:0]    i_instr,
    input  logic [DATA_W_P-1:0]                i_rs_data,
    input  logic [DATA_W_P-1:0]                i_rt_data,
    input  logic [isa_cpu_pkg::ADDR_W-1:0]     i_pc,
    output logic [DATA_W_P-1:0]                o_alu_result,
    output logic                               o_branch_taken,
    output logic                               o_wb_en,
    output logic [isa_cpu_pkg::REG_ADDR_W-1:0] o_wb_addr,
    output logic [DATA_W_P-1:0]                o_store_data
);
    import isa_cpu_pkg::*;

    opcode_e                    opcode;
    logic                       func;
    logic signed [DATA_W_P-1:0] rs_q;
    logic signed [DATA_W_P-1:0] rt_q;
    logic signed [DATA_W_P-1:0] imm_ext;
    logic signed [DATA_W_P-1:0] pc_ext;
    logic signed [DATA_W_P-1:0] alu_d;
    logic signed [DATA_W_P-1:0] result_q;

    assign opcode  = opcode_e'(i_instr[OPC_MSB:OPC_LSB]);
    assign func    = i_instr[FUNC_BIT];
    assign imm_ext = {{(DATA_W_P-IMM_W){i_instr[IMM_W-1]}}, i_instr[IMM_W-1:0]};
    // PC has already stepped past the BEQ, so the target is PC+1+imm
    assign pc_ext  = DATA_W_P'(i_pc);

    always_ff @(posedge clk)
    begin
        if (i_state == S_DECODE)
        begin
            rs_q <= i_rs_data;
            rt_q <= i_rt_data;
        end
        if (i_state == S_EXEC)
        begin
            result_q <= alu_d;
        end
    end

    // ====================
    // ALU
    // ====================
    always_comb
    begin
        case (opcode)
            OP_RTYPE0:    alu_d = func ? (rs_q - rt_q) : (rs_q + rt_q);
            // Multiply keeps the low bits only
            OP_RTYPE1:    alu_d = func ? (rs_q * rt_q) : DATA_W_P'(rs_q < rt_q);
            OP_LW, OP_SW: alu_d = rs_q + imm_ext;
            OP_BEQ:       alu_d = pc_ext + imm_ext;
            default:      alu_d = '0;
        endcase
    end

    // High for the cycle after execute, when fetch reloads the PC
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_branch_taken <= 1'b0;
        end
        else
        begin
            o_branch_taken <= (i_state == S_EXEC) && (opcode == OP_BEQ) && (rs_q == rt_q);
        end
    end

    // R-type writes rd, a load writes rt
    assign o_wb_en      = (i_state == S_R_WB) || (i_state == S_MEM_WB);
    assign o_wb_addr    = (i_state == S_R_WB) ? i_instr[RD_MSB:RD_LSB] : i_instr[RT_MSB:RT_LSB];
    assign o_alu_result = result_q;
    assign o_store_data = rt_q;

endmodule

// ==== cpu_fetch.sv ====
// Instruction fetch unit.
// Holds the program counter and the instruction register. The request is a
// registered one-cycle pulse issued from S_FETCH. The PC steps past the
// fetched word when the instruction memory answers. J and a taken BEQ
// reload it later.
module cpu_fetch (
    input  logic                            clk,
    input  logic                            rst_n,
    input  isa_cpu_pkg::cpu_state_e         i_state,
    input  logic                            i_branch_taken,
    input  logic [isa_cpu_pkg::ADDR_W-1:0]  i_alu_result,
    input  logic                            i_imem_valid,
    input  logic [isa_cpu_pkg::INSTR_W-1:0] i_imem_data,
    output logic                            o_imem_req,
    output logic [isa_cpu_pkg::ADDR_W-1:0]  o_imem_addr,
    output logic [isa_cpu_pkg::INSTR_W-1:0] o_instr
);
    import isa_cpu_pkg::*;

    logic [ADDR_W-1:0]  pc_q;
    logic [INSTR_W-1:0] ir_q;
    logic               fetch_done;
    logic               jump;

    assign fetch_done = (i_state == S_FETCH_WAIT) && i_imem_valid;
    assign jump       = (i_state == S_DECODE) && (opcode_e'(ir_q[OPC_MSB:OPC_LSB]) == OP_J);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_imem_req <= 1'b0;
            pc_q       <= PC_BASE;
            ir_q       <= '0;
        end
        else
        begin
            o_imem_req <= (i_state == S_FETCH);
            if (fetch_done)
            begin
                pc_q <= pc_q + 1'b1;
                ir_q <= i_imem_data;
            end
            // Jumps stay inside program space
            else if (jump)
            begin
                pc_q <= PC_BASE + ADDR_W'(ir_q[JMP_W-1:0]);
            end
            else if (i_branch_taken)
            begin
                pc_q <= i_alu_result;
            end
        end
    end

    // Address stays stable until the memory answers
    assign o_imem_addr = pc_q;
    assign o_instr     = ir_q;

endmodule

// ==== cpu_mem_access.sv ====
// Data memory access unit.
// Turns the word index from execute into a byte address and pulses the read
// or write strobe in S_MEM_REQ. Address and write data hold until the
// memory answers. Load data is captured on the valid pulse.
module cpu_mem_access #(
    parameter int DATA_W_P = isa_cpu_pkg::DATA_W
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  isa_cpu_pkg::cpu_state_e        i_state,
    input  logic                           i_is_store,
    input  logic [DATA_W_P-1:0]            i_index,
    input  logic [DATA_W_P-1:0]            i_store_data,
    input  logic                           i_dmem_valid,
    input  logic [DATA_W_P-1:0]            i_dmem_rdata,
    output logic                           o_dmem_rd,
    output logic                           o_dmem_wr,
    output logic [isa_cpu_pkg::ADDR_W-1:0] o_dmem_addr,
    output logic [DATA_W_P-1:0]            o_dmem_wdata,
    output logic                           o_mem_done,
    output logic [DATA_W_P-1:0]            o_load_data
);
    import isa_cpu_pkg::*;

    logic                req;
    logic [DATA_W_P-1:0] load_q;

    // S_MEM_REQ lasts one cycle, so each strobe is a single pulse
    assign req       = (i_state == S_MEM_REQ);
    assign o_dmem_rd = req && !i_is_store;
    assign o_dmem_wr = req && i_is_store;

    // Word index times two plus the data offset
    assign o_dmem_addr  = {i_index[ADDR_W-2:0], 1'b0} + DMEM_BASE;
    assign o_dmem_wdata = i_store_data;

    assign o_mem_done = (i_state == S_MEM_WAIT) && i_dmem_valid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            load_q <= '0;
        end
        else if (o_mem_done && !i_is_store)
        begin
            load_q <= i_dmem_rdata;
        end
    end

    assign o_load_data = load_q;

endmodule

// ==== cpu_regfile.sv ====
// General register file of the core.
// Sixteen signed registers with two combinational read ports for rs and rt
// and one synchronous write port. All registers clear to zero on reset.
module cpu_regfile #(
    parameter int DATA_W_P = isa_cpu_pkg::DATA_W
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [isa_cpu_pkg::REG_ADDR_W-1:0] i_rs_addr,
    input  logic [isa_cpu_pkg::REG_ADDR_W-1:0] i_rt_addr,
    input  logic                               i_wr_en,
    input  logic [isa_cpu_pkg::REG_ADDR_W-1:0] i_wr_addr,
    input  logic [DATA_W_P-1:0]                i_wr_data,
    output logic [DATA_W_P-1:0]                o_rs_data,
    output logic [DATA_W_P-1:0]                o_rt_data
);
    import isa_cpu_pkg::*;

    logic signed [DATA_W_P-1:0] regs_q [REG_COUNT];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs_q[i] <= '0;
            end
        end
        else if (i_wr_en)
        begin
            regs_q[i_wr_addr] <= i_wr_data;
        end
    end

    // Reads see the old value during a write
    assign o_rs_data = regs_q[i_rs_addr];
    assign o_rt_data = regs_q[i_rt_addr];

endmodule

// ==== isa_cpu.f ====
isa_cpu_pkg.sv
cpu_fetch.sv
cpu_control.sv
cpu_regfile.sv
cpu_execute.sv
cpu_mem_access.sv
isa_cpu.sv
isa_cpu_assert.sv
isa_cpu_tb.sv

// ==== isa_cpu.sv ====
// Top level of the multi-cycle 16-bit core.
// Connects fetch, control, the register file, execute and memory access.
// Instruction and data memories sit outside and answer each request strobe
// with a one-cycle valid pulse. o_io_stall drops for one cycle each time an
// instruction completes.
module isa_cpu #(
    parameter int DATA_W_P = isa_cpu_pkg::DATA_W
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            i_imem_valid,
    input  logic [isa_cpu_pkg::INSTR_W-1:0] i_imem_data,
    input  logic                            i_dmem_valid,
    input  logic [DATA_W_P-1:0]             i_dmem_rdata,
    output logic                            o_imem_req,
    output logic [isa_cpu_pkg::ADDR_W-1:0]  o_imem_addr,
    output logic                            o_dmem_rd,
    output logic                            o_dmem_wr,
    output logic [isa_cpu_pkg::ADDR_W-1:0]  o_dmem_addr,
    output logic [DATA_W_P-1:0]             o_dmem_wdata,
    output logic                            o_io_stall
);
    import isa_cpu_pkg::*;

    cpu_state_e            state;
    logic [INSTR_W-1:0]    instr;
    logic                  branch_taken;
    logic                  mem_done;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W_P-1:0]   rs_data;
    logic [DATA_W_P-1:0]   rt_data;
    logic [DATA_W_P-1:0]   alu_result;
    logic [DATA_W_P-1:0]   store_data;
    logic [DATA_W_P-1:0]   load_data;
    logic [DATA_W_P-1:0]   wr_data;

    // Loads write back the memory word, R-type the ALU result
    assign wr_data = (state == S_MEM_WB) ? load_data : alu_result;

    cpu_fetch u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_state        (state),
        .i_branch_taken (branch_taken),
        .i_alu_result   (alu_result[ADDR_W-1:0]),
        .i_imem_valid   (i_imem_valid),
        .i_imem_data    (i_imem_data),
        .o_imem_req     (o_imem_req),
        .o_imem_addr    (o_imem_addr),
        .o_instr        (instr)
    );

    cpu_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_instr      (instr),
        .i_imem_valid (i_imem_valid),
        .i_mem_done   (mem_done),
        .o_state      (state),
        .o_io_stall   (o_io_stall)
    );

    cpu_regfile #(
        .DATA_W_P (DATA_W_P)
    ) u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_rs_addr (instr[RS_MSB:RS_LSB]),
        .i_rt_addr (instr[RT_MSB:RT_LSB]),
        .i_wr_en   (wb_en),
        .i_wr_addr (wb_addr),
        .i_wr_data (wr_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    cpu_execute #(
        .DATA_W_P (DATA_W_P)
    ) u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_state        (state),
        .i_instr        (instr),
        .i_rs_data      (rs_data),
        .i_rt_data      (rt_data),
        .i_pc           (o_imem_addr),
        .o_alu_result   (alu_result),
        .o_branch_taken (branch_taken),
        .o_wb_en        (wb_en),
        .o_wb_addr      (wb_addr),
        .o_store_data   (store_data)
    );

    // LW and SW differ only in the opcode LSB
    cpu_mem_access #(
        .DATA_W_P (DATA_W_P)
    ) u_mem_access (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_state      (state),
        .i_is_store   (instr[OPC_LSB]),
        .i_index      (alu_result),
        .i_store_data (store_data),
        .i_dmem_valid (i_dmem_valid),
        .i_dmem_rdata (i_dmem_rdata),
        .o_dmem_rd    (o_dmem_rd),
        .o_dmem_wr    (o_dmem_wr),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_mem_done   (mem_done),
        .o_load_data  (load_data)
    );

endmodule

// ==== isa_cpu_assert.sv ====
// Protocol checks for the core's memory strobes and stall output.
// Bound into every instance of the top level, the checks are idle while
// reset is asserted.
module isa_cpu_assert (
    input logic clk,
    input logic rst_n,
    input logic i_imem_req,
    input logic i_dmem_rd,
    input logic i_dmem_wr,
    input logic i_io_stall
);
    timeunit 1ns;
    timeprecision 100ps;

    // ====================
    // Strobes
    // ====================
    imem_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        i_imem_req |=> !i_imem_req)
        else $error("instruction request held longer than one cycle");

    dmem_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        i_dmem_rd |=> !i_dmem_rd)
        else $error("data read strobe held longer than one cycle");

    dmem_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        i_dmem_wr |=> !i_dmem_wr)
        else $error("data write strobe held longer than one cycle");

    rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_dmem_rd && i_dmem_wr))
        else $error("data read and write strobes active together");

    // Completion drops stall for one cycle only
    stall_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        !i_io_stall |=> i_io_stall)
        else $error("stall low for more than one cycle");

endmodule

bind isa_cpu isa_cpu_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_imem_req (o_imem_req),
    .i_dmem_rd  (o_dmem_rd),
    .i_dmem_wr  (o_dmem_wr),
    .i_io_stall (o_io_stall)
);

// ==== isa_cpu_pkg.sv ====
// Shared definitions for the 16-bit multi-cycle core.
// Holds the widths, the memory bases, the instruction field positions and the
// opcode and FSM encodings. Every unit of the core imports it, and so does
// the testbench.
package isa_cpu_pkg;

    // ====================
    // Widths
    // ====================
    localparam int DATA_W     = 16;
    localparam int INSTR_W    = 16;
    localparam int ADDR_W     = 16;
    localparam int REG_COUNT  = 16;
    localparam int REG_ADDR_W = 4;

    // Reset PC, also the base that J adds its field to
    localparam logic [ADDR_W-1:0] PC_BASE   = 16'h1000;
    // Byte address of a data word is 2*(rs+imm) plus this offset
    localparam logic [ADDR_W-1:0] DMEM_BASE = 16'h1000;

    // ====================
    // Instruction fields
    // ====================
    localparam int OPC_MSB  = 15;
    localparam int OPC_LSB  = 13;
    localparam int RS_MSB   = 12;
    localparam int RS_LSB   = 9;
    localparam int RT_MSB   = 8;
    localparam int RT_LSB   = 5;
    localparam int RD_MSB   = 4;
    localparam int RD_LSB   = 1;
    localparam int FUNC_BIT = 0;
    // Signed immediate in bits 4..0, jump field in bits 12..0
    localparam int IMM_W    = 5;
    localparam int JMP_W    = 13;

    // Opcodes, the R-type pair is split further by the function bit
    typedef enum logic [2:0] {
        OP_RTYPE0 = 3'b000,
        OP_RTYPE1 = 3'b001,
        OP_LW     = 3'b010,
        OP_SW     = 3'b011,
        OP_BEQ    = 3'b100,
        OP_J      = 3'b101,
        OP_RSV6   = 3'b110,
        OP_RSV7   = 3'b111
    } opcode_e;

    // Main FSM states
    typedef enum logic [3:0] {
        S_FETCH,
        S_FETCH_WAIT,
        S_DECODE,
        S_EXEC,
        S_R_WB,
        S_MEM_REQ,
        S_MEM_WAIT,
        S_MEM_WB,
        S_DONE
    } cpu_state_e;

endpackage

// ==== isa_cpu_tb.sv ====
// Testbench for the multi-cycle 16-bit core.
// Runs a table of small programs against behavioral instruction and data
// memories with random latency. Store traffic, load count, fetch order and
// completion pulses are checked for each program, then a summary line is
// printed.
module isa_cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import isa_cpu_pkg::*;

    localparam int NUM_TESTS    = 4;
    localparam int MAX_INSTR    = 12;
    localparam int MAX_STORE    = 4;
    localparam int DMEM_WORDS   = 64;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 100;
    localparam int WD_CYCLES    = NUM_TESTS * (MAX_INSTR * 20 + RESET_CYCLES + 4);

    logic        clk;
    logic        rst_n;
    logic        i_imem_valid;
    logic [15:0] i_imem_data;
    logic        i_dmem_valid;
    logic [15:0] i_dmem_rdata;
    logic        o_imem_req;
    logic [15:0] o_imem_addr;
    logic        o_dmem_rd;
    logic        o_dmem_wr;
    logic [15:0] o_dmem_addr;
    logic [15:0] o_dmem_wdata;
    logic        o_io_stall;

    // ====================
    // Program table
    // ====================
    string       test_name [NUM_TESTS];
    logic [15:0] prog [NUM_TESTS][MAX_INSTR];
    logic [15:0] init_data [NUM_TESTS][4];
    int          n_instr [NUM_TESTS];
    int          n_store [NUM_TESTS];
    int          n_load [NUM_TESTS];
    logic [15:0] exp_addr [NUM_TESTS][MAX_STORE];
    logic [15:0] exp_data [NUM_TESTS][MAX_STORE];
    int          exp_fetch [NUM_TESTS][MAX_INSTR];

    // Memory models and traffic logs
    logic [15:0] dmem [DMEM_WORDS];
    int unsigned seed = 14;
    int          cur;
    int          stall_cnt;
    int          fetch_cnt;
    int          store_cnt;
    int          load_cnt;
    int          fetch_log [32];
    logic [15:0] st_addr_log [16];
    logic [15:0] st_data_log [16];
    logic [15:0] first_fetch;
    int          i_wait;
    int          d_wait;
    logic        d_write;
    int          d_index;
    logic [15:0] d_wdata;
    int          test_errs;
    int          total_errs;
    int          tests_failed;

    isa_cpu u_dut (.*);

    function automatic int next_latency();
        seed = seed * 32'd1103515245 + 32'd12345;
        return 1 + int'((seed >> 16) % 4);
    endfunction

    function automatic logic [15:0] enc_r(input logic [2:0] op, input int rs, input int rt,
                                          input int rd, input logic f);
        return {op, 4'(rs), 4'(rt), 4'(rd), f};
    endfunction

    function automatic logic [15:0] enc_i(input logic [2:0] op, input int rs, input int rt,
                                          input int imm);
        return {op, 4'(rs), 4'(rt), 5'(imm)};
    endfunction

    // Data byte address back to a word of the 64-word model
    function automatic int dmem_index(input logic [15:0] addr);
        logic [15:0] off;
        off = addr - DMEM_BASE;
        return int'(off[6:1]);
    endfunction

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            for (int k = 0; k < MAX_INSTR; k++)
            begin
                prog[t][k] = 16'h0000;
                exp_fetch[t][k] = k;
            end
        end
        // r3=7+(-3), r4=7-(-3), r5=(-3<7), r6=7*(-3)
        test_name[0] = "alu";
        init_data[0] = '{16'd7, 16'hFFFD, 16'd0, 16'd0};
        prog[0][0] = enc_i(OP_LW, 0, 1, 0);
        prog[0][1] = enc_i(OP_LW, 0, 2, 1);
        prog[0][2] = enc_r(OP_RTYPE0, 1, 2, 3, 1'b0);
        prog[0][3] = enc_r(OP_RTYPE0, 1, 2, 4, 1'b1);
        prog[0][4] = enc_r(OP_RTYPE1, 2, 1, 5, 1'b0);
        prog[0][5] = enc_r(OP_RTYPE1, 1, 2, 6, 1'b1);
        for (int k = 0; k < 4; k++)
        begin
            prog[0][6+k] = enc_i(OP_SW, 0, 3 + k, 8 + k);
        end
        n_instr[0] = 10;
        n_store[0] = 4;
        n_load[0]  = 2;
        exp_addr[0] = '{16'h1010, 16'h1012, 16'h1014, 16'h1016};
        exp_data[0] = '{16'd4, 16'd10, 16'd1, 16'hFFEB};
        // Base register r7 holds 6 so negative offsets reach below DMEM_BASE
        test_name[1] = "neg_imm";
        init_data[1] = '{16'd0, 16'd0, 16'h1234, 16'd6};
        prog[1][0] = enc_i(OP_LW, 0, 1, 2);
        prog[1][1] = enc_i(OP_LW, 0, 7, 3);
        prog[1][2] = enc_i(OP_SW, 7, 1, -1);
        prog[1][3] = enc_i(OP_LW, 7, 2, -1);
        prog[1][4] = enc_i(OP_SW, 7, 2, -16);
        prog[1][5] = enc_i(OP_LW, 7, 3, -16);
        prog[1][6] = enc_i(OP_SW, 0, 3, 7);
        n_instr[1] = 7;
        n_store[1] = 3;
        n_load[1]  = 4;
        exp_addr[1] = '{16'h100A, 16'h0FEC, 16'h100E, 16'h0};
        exp_data[1] = '{16'h1234, 16'h1234, 16'h1234, 16'h0};
        // Taken BEQ skips word 4 and J skips word 8
        test_name[2] = "branch";
        init_data[2] = '{16'd3, 16'd3, 16'd4, 16'd0};
        prog[2][0] = enc_i(OP_LW, 0, 1, 0);
        prog[2][1] = enc_i(OP_LW, 0, 2, 1);
        prog[2][2] = enc_i(OP_LW, 0, 3, 2);
        prog[2][3] = enc_i(OP_BEQ, 1, 2, 1);
        prog[2][4] = enc_i(OP_SW, 0, 1, 8);
        prog[2][5] = enc_i(OP_BEQ, 1, 3, 1);
        prog[2][6] = enc_i(OP_SW, 0, 3, 9);
        prog[2][7] = {OP_J, 13'd9};
        prog[2][8] = enc_i(OP_SW, 0, 1, 10);
        prog[2][9] = enc_i(OP_SW, 0, 2, 11);
        n_instr[2] = 8;
        n_store[2] = 2;
        n_load[2]  = 3;
        exp_addr[2] = '{16'h1012, 16'h1016, 16'h0, 16'h0};
        exp_data[2] = '{16'd4, 16'd3, 16'h0, 16'h0};
        exp_fetch[2] = '{0, 1, 2, 3, 5, 6, 7, 9, 0, 0, 0, 0};
        test_name[3] = "reserved";
        init_data[3] = '{16'h0055, 16'd0, 16'd0, 16'd0};
        prog[3][0] = enc_i(OP_LW, 0, 1, 0);
        prog[3][1] = enc_i(OP_RSV6, 1, 1, 4);
        prog[3][2] = 16'hFFFF;
        prog[3][3] = enc_i(OP_SW, 0, 1, 4);
        n_instr[3] = 4;
        n_store[3] = 1;
        n_load[3]  = 1;
        exp_addr[3] = '{16'h1008, 16'h0, 16'h0, 16'h0};
        exp_data[3] = '{16'h0055, 16'h0, 16'h0, 16'h0};
    endtask

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ====================
    // Memory models
    // ====================
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!rst_n)
            begin
                stall_cnt = 0;
                fetch_cnt = 0;
                store_cnt = 0;
                load_cnt  = 0;
                i_wait    = 0;
                d_wait    = 0;
            end
            else
            begin
                if (!o_io_stall)
                begin
                    stall_cnt++;
                end
                if (o_imem_req)
                begin
                    if (fetch_cnt == 0)
                    begin
                        first_fetch = o_imem_addr;
                    end
                    if (fetch_cnt < 32)
                    begin
                        fetch_log[fetch_cnt] = int'(o_imem_addr - PC_BASE);
                    end
                    fetch_cnt++;
                    i_wait = next_latency();
                end
                if (o_dmem_rd || o_dmem_wr)
                begin
                    d_write = o_dmem_wr;
                    d_index = dmem_index(o_dmem_addr);
                    d_wdata = o_dmem_wdata;
                    d_wait  = next_latency();
                    if (o_dmem_wr && store_cnt < 16)
                    begin
                        st_addr_log[store_cnt] = o_dmem_addr;
                        st_data_log[store_cnt] = o_dmem_wdata;
                    end
                    store_cnt += o_dmem_wr ? 1 : 0;
                    load_cnt  += o_dmem_rd ? 1 : 0;
                end
            end
            @(posedge clk);
            #1;
            i_imem_valid = 1'b0;
            i_dmem_valid = 1'b0;
            if (i_wait > 0)
            begin
                i_wait--;
                if (i_wait == 0)
                begin
                    i_imem_valid = 1'b1;
                    i_imem_data  = (fetch_log[fetch_cnt-1] < MAX_INSTR) ?
                                   prog[cur][fetch_log[fetch_cnt-1]] : 16'h0000;
                end
            end
            if (d_wait > 0)
            begin
                d_wait--;
                if (d_wait == 0)
                begin
                    i_dmem_valid = 1'b1;
                    if (d_write)
                    begin
                        dmem[d_index] = d_wdata;
                    end
                    i_dmem_rdata = dmem[d_index];
                end
            end
        end
    end

    task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
        assert (exp === act)
        else
        begin
            $display("FAILED %s %s: expected %h, actual %h", test_name[cur], what, exp, act);
            test_errs++;
        end
    endtask

    task automatic run_test(input int t);
        cur       = t;
        test_errs = 0;
        rst_n     = 1'b0;
        for (int w = 0; w < DMEM_WORDS; w++)
        begin
            dmem[w] = (w < 4) ? init_data[t][w] : (16'hA500 ^ 16'(w * 3));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        assert (o_io_stall && !o_imem_req && !o_dmem_rd && !o_dmem_wr)
        else
        begin
            $display("%s: stall low or a strobe active during reset", test_name[t]);
            test_errs++;
        end
        @(posedge clk);
        #1 rst_n = 1'b1;
        while (stall_cnt < n_instr[t])
        begin
            @(posedge clk);
        end
        check_value("first fetch address", PC_BASE, first_fetch);
        check_value("fetch count", 16'(n_instr[t]), 16'(fetch_cnt));
        for (int k = 0; k < n_instr[t] && k < fetch_cnt; k++)
        begin
            check_value($sformatf("fetch %0d", k), 16'(exp_fetch[t][k]), 16'(fetch_log[k]));
        end
        check_value("load count", 16'(n_load[t]), 16'(load_cnt));
        check_value("store count", 16'(n_store[t]), 16'(store_cnt));
        for (int k = 0; k < n_store[t] && k < store_cnt; k++)
        begin
            check_value($sformatf("store %0d addr", k), exp_addr[t][k], st_addr_log[k]);
            check_value($sformatf("store %0d data", k), exp_data[t][k], st_data_log[k]);
        end
        $display("test %s: %s (%0d errors)", test_name[t], test_errs ? "fail" : "ok", test_errs);
        total_errs += test_errs;
        tests_failed += (test_errs != 0) ? 1 : 0;
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        rst_n        = 1'b0;
        i_imem_valid = 1'b0;
        i_imem_data  = 16'h0000;
        i_dmem_valid = 1'b0;
        i_dmem_rdata = 16'h0000;
        cur          = 0;
        total_errs   = 0;
        tests_failed = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed, total_errs);
        if (total_errs == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("timeout: the core did not complete the expected instructions");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module isa_cpu_tb -f isa_cpu.f -o isa_cpu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/isa_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
